//--- common/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  parameter int xlen = 32;                    // Data and address width.

  // One bus word, identified by its word address.
  typedef struct packed {
    logic        valid;                       // Entry holds a live address.
    logic [29:0] addr;                        // Byte address bits 31:2.
  } word_tag_t;

  typedef struct packed {
    logic            read;                    // Read strobe.
    logic [xlen-1:0] address;                 // Word aligned read address.
  } mem_req_t;

  typedef struct packed {
    logic            request_ready;           // Bus takes the read this cycle.
    logic            read_data_valid;         // One cycle pulse per accepted read.
    logic [xlen-1:0] read_data;
  } mem_rsp_t;

  typedef struct packed {
    logic [xlen-1:0] istr;                    // Upper half unused by compressed ones.
    logic [xlen-1:0] pc;
  } istr_entry_t;

  typedef enum logic [1:0] {
    pc_hold,                                  // Keep the current pc.
    pc_jump,                                  // Redirect from execute.
    pc_step                                   // Advance past the current instruction.
  } next_pc_sel_t;

  // Full length when the low two bits are both one.
  typedef enum logic {
    istr_half,
    istr_full
  } istr_len_t;

endpackage

`default_nettype wire

//--- design/fetch_pc.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_pc #(
  parameter logic [fetch_pkg::xlen-1:0] reset_addr = '0
) (
  input  logic                       clk,
  input  logic                       rest,
  input  logic                       jump_en,
  input  logic [fetch_pkg::xlen-1:0] jump_addr,
  input  logic                       istr_ok,
  input  fetch_pkg::istr_len_t       istr_len,
  input  logic                       queue_full,
  output logic [fetch_pkg::xlen-1:0] pc,
  output logic [fetch_pkg::xlen-1:0] next_pc,
  output logic                       istr_write
);

  fetch_pkg::next_pc_sel_t sel;

  // A redirect from execute beats a step.
  always_comb begin
    if (jump_en) begin
      sel = fetch_pkg::pc_jump;
    end else if (istr_ok && !queue_full) begin
      sel = fetch_pkg::pc_step;                // Instruction is complete and has a slot.
    end else begin
      sel = fetch_pkg::pc_hold;
    end
  end

  always_comb begin
    case (sel)
      fetch_pkg::pc_jump: next_pc = jump_addr;
      fetch_pkg::pc_step: next_pc = pc + ((istr_len == fetch_pkg::istr_full) ? 32'd4 : 32'd2);
      default:            next_pc = pc;        // Hold.
    endcase
  end

  assign istr_write = (sel == fetch_pkg::pc_step); // Entry goes out with the old pc.

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      pc <= reset_addr;
    end else begin
      pc <= next_pc;                           // Equal to pc on a hold.
    end
  end

endmodule

`default_nettype wire

//--- design/prefetch_addr.sv
`timescale 1ns/1ns
`default_nettype none

module prefetch_addr #(
  parameter int prefetch_num = 2,
  parameter int wait_depth   = 2,
  parameter int hist_depth   = 2
) (
  input  logic [fetch_pkg::xlen-1:0]                      pc,
  input  logic [fetch_pkg::xlen-1:0]                      next_pc,
  input  logic [1:0]                                      word_request,
  input  fetch_pkg::word_tag_t [wait_depth+hist_depth-1:0] sent_tags,
  input  logic                                            wait_full,
  output fetch_pkg::mem_req_t                             mem_req
);

  logic [prefetch_num-1:0][29:0] pf_word;      // Words from next_pc onward.
  logic [prefetch_num-1:0]       pf_sent;      // Already held or outstanding.
  logic [29:0]                   rd_word;
  logic                          need;

  always_comb begin
    for (int i = 0; i < prefetch_num; i++) begin
      pf_word[i] = next_pc[31:2] + 30'(i);
      pf_sent[i] = 1'b0;
      for (int j = 0; j < wait_depth + hist_depth; j++) begin
        if (sent_tags[j].valid && (sent_tags[j].addr == pf_word[i])) begin
          pf_sent[i] = 1'b1;
        end
      end
    end
  end

  // Demand from the assembler first, then the nearest missing prefetch word.
  always_comb begin
    need    = 1'b1;
    rd_word = pc[31:2];
    if (word_request[0]) begin
      rd_word = pc[31:2];                      // Word holding pc.
    end else if (word_request[1]) begin
      rd_word = pc[31:2] + 30'd1;              // Upper half of a straddling instruction.
    end else begin
      need = 1'b0;
      for (int i = prefetch_num - 1; i >= 0; i--) begin
        if (!pf_sent[i]) begin
          need    = 1'b1;
          rd_word = pf_word[i];                // Lowest index wins.
        end
      end
    end
  end

  assign mem_req.read    = need && !wait_full; // Never overrun the outstanding queue.
  assign mem_req.address = {rd_word, 2'b00};

endmodule

`default_nettype wire

//--- fetch_buffer/fetch_word_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_word_buffer #(
  parameter int wait_depth = 2,
  parameter int hist_depth = 2
) (
  input  logic                                       clk,
  input  logic                                       rest,
  input  fetch_pkg::mem_req_t                        mem_req,
  input  fetch_pkg::mem_rsp_t                        mem_rsp,
  output logic                                       wait_full,
  output fetch_pkg::word_tag_t [wait_depth-1:0]      pend_tags,
  output fetch_pkg::word_tag_t [hist_depth-1:0]      hist_tags,
  output logic [hist_depth-1:0][fetch_pkg::xlen-1:0] hist_data,
  output fetch_pkg::word_tag_t                       head_tag
);

  fetch_pkg::word_tag_t [wait_depth-1:0] pend_q;   // Entry 0 is the oldest read.
  fetch_pkg::word_tag_t [wait_depth-1:0] pend_nxt;
  logic                                  push;
  logic                                  pop;

  assign push = mem_req.read && mem_rsp.request_ready;   // Read accepted.
  assign pop  = mem_rsp.read_data_valid && pend_q[0].valid;

  assign wait_full = !rest || pend_q[wait_depth-1].valid; // No reads while in reset.
  assign pend_tags = pend_q;
  assign head_tag  = '{valid: pop, addr: pend_q[0].addr}; // Tags the arriving data.

  // Compacted queue. A pop shifts toward entry 0 and a push fills the first free slot.
  always_comb begin
    logic placed;
    pend_nxt = pend_q;
    placed   = 1'b0;
    if (pop) begin
      for (int i = 0; i < wait_depth - 1; i++) begin
        pend_nxt[i] = pend_q[i+1];
      end
      pend_nxt[wait_depth-1] = '0;
    end
    if (push) begin
      for (int i = 0; i < wait_depth; i++) begin
        if (!placed && !pend_nxt[i].valid) begin
          pend_nxt[i] = '{valid: 1'b1, addr: mem_req.address[31:2]};
          placed      = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      pend_q    <= '0;
      hist_tags <= '0;                         // All history invalid.
    end else begin
      pend_q <= pend_nxt;
      if (pop) begin
        hist_tags <= {hist_tags[hist_depth-2:0], head_tag}; // Newest at entry 0.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      hist_data <= {hist_data[hist_depth-2:0], mem_rsp.read_data};
    end
  end

endmodule

`default_nettype wire

//--- design/istr_assemble.sv
`timescale 1ns/1ns
`default_nettype none

module istr_assemble #(
  parameter int wait_depth = 2,
  parameter int hist_depth = 2
) (
  input  logic [fetch_pkg::xlen-1:0]                 pc,
  input  fetch_pkg::word_tag_t [hist_depth-1:0]      hist_tags,
  input  logic [hist_depth-1:0][fetch_pkg::xlen-1:0] hist_data,
  input  fetch_pkg::word_tag_t                       head_tag,
  input  fetch_pkg::mem_rsp_t                        mem_rsp,
  input  fetch_pkg::word_tag_t [wait_depth-1:0]      pend_tags,
  output logic [fetch_pkg::xlen-1:0]                 istr,
  output logic                                       istr_ok,
  output fetch_pkg::istr_len_t                       istr_len,
  output logic [1:0]                                 word_request
);

  fetch_pkg::word_tag_t [hist_depth:0]      avail_tag;  // History plus this cycle's word.
  logic [hist_depth:0][fetch_pkg::xlen-1:0] avail_data;
  logic [1:0][29:0]                         want;       // Word of pc and the one after.
  logic [1:0]                               held;
  logic [1:0]                               sent;
  logic [1:0][fetch_pkg::xlen-1:0]          word;
  logic [15:0]                              half_lo;
  logic [15:0]                              half_hi;
  logic                                     have_hi;

  assign avail_tag  = {head_tag, hist_tags};
  assign avail_data = {mem_rsp.read_data, hist_data};

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      want[w] = pc[31:2] + 30'(w);
      held[w] = 1'b0;
      sent[w] = 1'b0;
      word[w] = '0;
      for (int j = 0; j <= hist_depth; j++) begin
        if (avail_tag[j].valid && (avail_tag[j].addr == want[w])) begin
          held[w] = 1'b1;
          word[w] = avail_data[j];
        end
      end
      for (int j = 0; j < wait_depth; j++) begin
        if (pend_tags[j].valid && (pend_tags[j].addr == want[w])) begin
          sent[w] = 1'b1;                      // Outstanding on the bus.
        end
      end
    end
  end

  assign half_lo = pc[1] ? word[0][31:16] : word[0][15:0];
  assign half_hi = pc[1] ? word[1][15:0] : word[0][31:16];   // Crosses into next word.
  assign have_hi = pc[1] ? held[1] : held[0];

  assign istr     = {half_hi, half_lo};
  assign istr_len = (half_lo[1:0] == 2'b11) ? fetch_pkg::istr_full : fetch_pkg::istr_half;
  assign istr_ok  = held[0] && ((istr_len == fetch_pkg::istr_half) || have_hi);

  assign word_request[0] = !held[0] && !sent[0];
  // Next word only matters for a full instruction at the upper half.
  assign word_request[1] = held[0] && pc[1] && (istr_len == fetch_pkg::istr_full)
                           && !held[1] && !sent[1];

endmodule

`default_nettype wire

//--- design/istr_queue.sv
`timescale 1ns/1ns
`default_nettype none

module istr_queue #(
  parameter int istr_depth = 2
) (
  input  logic                   clk,
  input  logic                   rest,
  input  logic                   flush_en,
  input  logic                   write,
  input  fetch_pkg::istr_entry_t write_entry,
  input  logic                   fd_ready,
  output fetch_pkg::istr_entry_t fd_entry,
  output logic                   fd_valid,
  output logic                   full
);

  localparam int pw = (istr_depth > 1) ? $clog2(istr_depth) : 1;
  localparam int cw = $clog2(istr_depth + 1);

  fetch_pkg::istr_entry_t mem [istr_depth];
  logic [pw-1:0]          wr_ptr;
  logic [pw-1:0]          rd_ptr;
  logic [cw-1:0]          count;
  logic                   do_write;
  logic                   do_read;

  assign full     = (count == cw'(istr_depth));
  assign fd_valid = (count != '0);
  assign fd_entry = mem[rd_ptr];
  assign do_write = write && !full && !flush_en;   // Flush drops a same-cycle write.
  assign do_read  = fd_valid && fd_ready;

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush_en) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;                            // Old path gone.
    end else begin
      if (do_write) begin
        wr_ptr <= (wr_ptr == pw'(istr_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == pw'(istr_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + cw'(do_write) - cw'(do_read);
    end
  end

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= write_entry;
    end
  end

endmodule

`default_nettype wire

//--- design/fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top #(
  parameter logic [fetch_pkg::xlen-1:0] reset_addr = '0,
  parameter int prefetch_num = 2,
  parameter int wait_depth   = 2,
  parameter int hist_depth   = 2,
  parameter int istr_depth   = 2
) (
  input  logic                          clk,
  input  logic                          rest,
  output fetch_pkg::mem_req_t           mem_req,
  input  fetch_pkg::mem_rsp_t           mem_rsp,
  input  logic                          jump_en,
  input  logic [fetch_pkg::xlen-1:0]    jump_addr,
  input  logic                          flush_en,
  output fetch_pkg::istr_entry_t        fd_entry,
  output logic                          fd_valid,
  input  logic                          fd_ready
);

  logic [fetch_pkg::xlen-1:0]                      pc;
  logic [fetch_pkg::xlen-1:0]                      next_pc;
  logic                                            istr_write;   // Pc steps, queue takes it.
  logic [fetch_pkg::xlen-1:0]                      istr;
  logic                                            istr_ok;
  fetch_pkg::istr_len_t                            istr_len;
  logic [1:0]                                      word_request; // Current word, next word.
  logic                                            wait_full;
  logic                                            queue_full;
  fetch_pkg::word_tag_t [wait_depth-1:0]           pend_tags;
  fetch_pkg::word_tag_t [hist_depth-1:0]           hist_tags;
  logic [hist_depth-1:0][fetch_pkg::xlen-1:0]      hist_data;
  fetch_pkg::word_tag_t                            head_tag;
  fetch_pkg::word_tag_t [wait_depth+hist_depth-1:0] sent_tags;
  fetch_pkg::istr_entry_t                          write_entry;

  assign sent_tags   = {hist_tags, pend_tags};     // Pending reads in the low entries.
  assign write_entry = '{istr: istr, pc: pc};

  fetch_pc #(
    .reset_addr (reset_addr)
  ) u_pc (
    .clk        (clk),
    .rest       (rest),
    .jump_en    (jump_en),
    .jump_addr  (jump_addr),
    .istr_ok    (istr_ok),
    .istr_len   (istr_len),
    .queue_full (queue_full),
    .pc         (pc),
    .next_pc    (next_pc),
    .istr_write (istr_write)
  );

  prefetch_addr #(
    .prefetch_num (prefetch_num),
    .wait_depth   (wait_depth),
    .hist_depth   (hist_depth)
  ) u_prefetch (
    .pc           (pc),
    .next_pc      (next_pc),
    .word_request (word_request),
    .sent_tags    (sent_tags),
    .wait_full    (wait_full),
    .mem_req      (mem_req)
  );

  fetch_word_buffer #(
    .wait_depth (wait_depth),
    .hist_depth (hist_depth)
  ) u_buffer (
    .clk        (clk),
    .rest       (rest),
    .mem_req    (mem_req),
    .mem_rsp    (mem_rsp),
    .wait_full  (wait_full),
    .pend_tags  (pend_tags),
    .hist_tags  (hist_tags),
    .hist_data  (hist_data),
    .head_tag   (head_tag)
  );

  istr_assemble #(
    .wait_depth   (wait_depth),
    .hist_depth   (hist_depth)
  ) u_assemble (
    .pc           (pc),
    .hist_tags    (hist_tags),
    .hist_data    (hist_data),
    .head_tag     (head_tag),
    .mem_rsp      (mem_rsp),
    .pend_tags    (pend_tags),
    .istr         (istr),
    .istr_ok      (istr_ok),
    .istr_len     (istr_len),
    .word_request (word_request)
  );

  istr_queue #(
    .istr_depth  (istr_depth)
  ) u_queue (
    .clk         (clk),
    .rest        (rest),
    .flush_en    (flush_en),
    .write       (istr_write),
    .write_entry (write_entry),
    .fd_ready    (fd_ready),
    .fd_entry    (fd_entry),
    .fd_valid    (fd_valid),
    .full        (queue_full)
  );

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
  parameter int half_period  = 5,              // 10 ns period.
  parameter int reset_cycles = 8
) (
  output logic clk,
  output logic rest
);

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // Release away from the rising edge.
  initial begin
    rest = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rest = 1'b1;
  end

endmodule

`default_nettype wire

//--- sim/tb_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fetch;

  localparam logic [31:0] reset_addr = 32'h0000_0000;
  localparam int          n_istr     = 100;                // Entries checked in total.
  localparam int          limit      = 30 * n_istr + 200;  // Cycle budget for the run.
  localparam int          mem_halves = 1024;               // 2 KiB of program.

  logic                   clk;
  logic                   rest;
  fetch_pkg::mem_req_t    mem_req;
  fetch_pkg::mem_rsp_t    mem_rsp;
  logic                   jump_en;
  logic [31:0]            jump_addr;
  logic                   flush_en;
  fetch_pkg::istr_entry_t fd_entry;
  logic                   fd_valid;
  logic                   fd_ready;

  logic [15:0] mem_half [mem_halves];
  logic [31:0] rng;
  logic [31:0] r;
  int          rsp_due [$];                  // Cycle from which each read may return.
  logic [31:0] rsp_addr [$];
  int          bus_cycle;
  int          cycle_cnt;
  int          received;
  int          value_errors;
  int          other_errors;
  int          jumps_done;
  logic [31:0] exp_pc;
  logic [31:0] exp_istr;
  logic [31:0] got_istr;

  tb_clock u_clock (
    .clk  (clk),
    .rest (rest)
  );

  fetch_top #(
    .reset_addr (reset_addr)
  ) u_dut (
    .clk       (clk),
    .rest      (rest),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp),
    .jump_en   (jump_en),
    .jump_addr (jump_addr),
    .flush_en  (flush_en),
    .fd_entry  (fd_entry),
    .fd_valid  (fd_valid),
    .fd_ready  (fd_ready)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_rand(output logic [31:0] v);
    rng = xorshift(rng);
    v   = rng;
  endtask

  function automatic logic [15:0] half_at(input logic [31:0] addr);
    return mem_half[addr[10:1]];             // Wraps within the program.
  endfunction

  // Expected instruction is the halfword at pc+2 above the halfword at pc.
  function automatic logic [31:0] istr_at(input logic [31:0] pc);
    return {half_at(pc + 32'd2), half_at(pc)};
  endfunction

  function automatic logic [31:0] pc_after(input logic [31:0] pc);
    logic [15:0] lo;
    lo = half_at(pc);
    return (lo[1:0] == 2'b11) ? pc + 32'd4 : pc + 32'd2;
  endfunction

  // Hash of the byte address. About five in eight come out full length.
  task automatic fill_memory();
    logic [31:0] h;
    for (int i = 0; i < mem_halves; i++) begin
      h = xorshift(xorshift(32'h52d7_8b75 ^ (i * 2)));
      mem_half[i] = h[20] ? (h[15:0] | 16'h0003) : h[15:0];
    end
  endtask

  task automatic print_counts();
    $display("checked %0d entries, %0d value errors, %0d other errors",
             received, value_errors, other_errors);
  endtask

  initial begin
    rng          = 32'h52d7_8b75;
    mem_rsp      = '0;
    jump_en      = 1'b0;
    jump_addr    = '0;
    flush_en     = 1'b0;
    fd_ready     = 1'b0;
    received     = 0;
    value_errors = 0;
    other_errors = 0;
    jumps_done   = 0;
    bus_cycle    = 0;
    exp_pc       = reset_addr;               // First entry comes from the reset address.
    fill_memory();
    repeat (4) @(posedge clk);
    assert (!fd_valid && !mem_req.read) else begin
      other_errors++;
      $display("fd_valid or mem_req.read was active during reset");
    end
    wait (received >= n_istr);
    repeat (2) @(posedge clk);
    print_counts();
    if (value_errors + other_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    other_errors++;
    $display("timeout: only %0d of %0d entries arrived in %0d cycles", received, n_istr, limit);
    print_counts();
    $display("SOME TESTS FAILED");
    $finish;
  end

  // Each accepted read is due back 1 to 4 cycles later.
  always @(posedge clk) begin
    bus_cycle++;
    if (rest && mem_req.read && mem_rsp.request_ready) begin
      next_rand(r);
      rsp_addr.push_back(mem_req.address);
      rsp_due.push_back(bus_cycle + int'(r[1:0]));
    end
  end

  always @(negedge clk) begin
    next_rand(r);
    mem_rsp.request_ready = r[8] | r[9];     // Ready three cycles in four.
    fd_ready              = (r[4:2] < 3'd3); // Decode mostly stalled.
    jump_en               = 1'b0;
    flush_en              = 1'b0;
    if (rsp_due.size() > 0 && rsp_due[0] <= bus_cycle) begin
      mem_rsp.read_data_valid = 1'b1;        // In order, one pulse per read.
      mem_rsp.read_data       = {half_at(rsp_addr[0] + 32'd2), half_at(rsp_addr[0])};
      rsp_due.delete(0);
      rsp_addr.delete(0);
    end else begin
      mem_rsp.read_data_valid = 1'b0;
      mem_rsp.read_data       = '0;
    end
    if (jumps_done < 3 && received >= 25 * (jumps_done + 1)) begin
      next_rand(r);
      jump_en   = 1'b1;                      // Redirect and flush together.
      flush_en  = 1'b1;
      fd_ready  = 1'b0;                      // No transfer in the flush cycle.
      jump_addr = r & 32'h0000_03fe;
      exp_pc    = r & 32'h0000_03fe;
      jumps_done++;
    end
  end

  // Compare every transfer toward decode with the reference stream.
  always @(posedge clk) begin
    if (rest && fd_valid && fd_ready) begin
      exp_istr = istr_at(exp_pc);
      got_istr = fd_entry.istr;
      if (exp_istr[1:0] != 2'b11) begin
        exp_istr[31:16] = '0;                // Upper half unused by a compressed one.
        got_istr[31:16] = '0;
      end
      assert (fd_entry.pc == exp_pc) else begin
        value_errors++;
        $display("error at %0t ns: fd_entry.pc is %h, expected %h", $time, fd_entry.pc, exp_pc);
      end
      assert (got_istr == exp_istr) else begin
        value_errors++;
        $display("error at %0t ns: fd_entry.istr is %h, expected %h",
                 $time, got_istr, exp_istr);
      end
      exp_pc = pc_after(exp_pc);
      received++;
    end
  end

endmodule

`default_nettype wire

//--- project.f
common/fetch_pkg.sv
design/fetch_pc.sv
design/prefetch_addr.sv
fetch_buffer/fetch_word_buffer.sv
design/istr_assemble.sv
design/istr_queue.sv
design/fetch_top.sv
sim/tb_clock.sv
sim/tb_fetch.sv

//--- Bender.yml
package:
  name: fetch_stage

sources:
  - common/fetch_pkg.sv
  - design/fetch_pc.sv
  - design/prefetch_addr.sv
  - fetch_buffer/fetch_word_buffer.sv
  - design/istr_assemble.sv
  - design/istr_queue.sv
  - design/fetch_top.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/tb_fetch.sv
